// File: files.f
+incdir+include
logic/rf_pkg.sv
logic/rf_index_sel.sv
logic/rf_bank.sv
logic/operand_fetch_fsm.sv
logic/operand_collect.sv
logic/fetch_stat_counter.sv
logic/operand_fetch_top.sv
test/operand_fetch_checker.sv
test/operand_fetch_assert.sv
test/operand_fetch_tb.sv

// File: test/operand_fetch_tb.sv
// Operand fetch testbench: clock, reset, watchdog, register preload and stimulus table
`timescale 1ns/1ns
`include "rf_defines.svh"

module operand_fetch_tb;
	import rf_pkg::*;

	typedef struct packed {
		idx_t src_1;
		idx_t src_2;
		idx_t src_3;
		logic exp_conflict;
		logic late_write; // Overwrite src_1 during pass A
		logic clear_first; // Pulse stat_clear before the issue
	} row_t;

	localparam int HAND_ROWS = 12;
	localparam int NUM_ROWS = 36;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * 6 + `RF_REG_COUNT + 4 + 10;

	logic clock, reset, write_enable, issue, stat_clear, expected_conflict;
	idx_t write_index;
	data_t write_data;
	fetch_req_t issue_req;
	logic busy, operands_valid, bank_conflict;
	data_t operand_1, operand_2, operand_3;
	stat_t fetch_count, conflict_count;
	int check_errors, fetches_seen, stim_errors, seed_value;
	row_t rows [NUM_ROWS];

	operand_fetch_top u_operand_fetch_top (
		.clock(clock), .reset(reset), .write_enable(write_enable),
		.write_index(write_index), .write_data(write_data), .issue(issue),
		.issue_req(issue_req), .stat_clear(stat_clear), .busy(busy),
		.operands_valid(operands_valid), .bank_conflict(bank_conflict),
		.operand_1(operand_1), .operand_2(operand_2), .operand_3(operand_3),
		.fetch_count(fetch_count), .conflict_count(conflict_count)
	);

	operand_fetch_checker u_checker (
		.clock(clock), .reset(reset), .write_enable(write_enable),
		.write_index(write_index), .write_data(write_data), .issue(issue),
		.issue_req(issue_req), .expected_conflict(expected_conflict),
		.stat_clear(stat_clear), .busy(busy), .operands_valid(operands_valid),
		.bank_conflict(bank_conflict), .operand_1(operand_1), .operand_2(operand_2),
		.operand_3(operand_3), .fetch_count(fetch_count), .conflict_count(conflict_count),
		.error_count(check_errors), .fetches_seen(fetches_seen)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		#(WATCHDOG_CYCLES * 10);
		$display("Run timed out: the stimulus table did not finish in %0d cycles",
			WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	function automatic row_t make_row(int a, int b, int c, logic conf, logic late,
		logic clear);
		row_t r;
		r.src_1 = idx_t'(a);
		r.src_2 = idx_t'(b);
		r.src_3 = idx_t'(c);
		r.exp_conflict = conf;
		r.late_write = late;
		r.clear_first = clear;
		return r;
	endfunction

	////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////

	task automatic build_table();
		idx_t a, b, c;
		rows[0] = make_row(2, 4, 6, 1, 0, 0); // All even
		rows[1] = make_row(8, 10, 13, 0, 0, 0);
		rows[2] = make_row(12, 15, 20, 0, 0, 0);
		rows[3] = make_row(22, 25, 27, 0, 0, 0);
		rows[4] = make_row(31, 30, 28, 0, 0, 0);
		rows[5] = make_row(33, 36, 39, 0, 0, 0);
		rows[6] = make_row(41, 43, 44, 0, 0, 0);
		rows[7] = make_row(45, 47, 49, 1, 0, 0); // All odd
		rows[8] = make_row(50, 53, 55, 0, 1, 0); // Write races the read
		rows[9] = make_row(50, 53, 55, 0, 0, 0); // Now sees the new value
		rows[10] = make_row(7, 9, 11, 1, 0, 1); // Counters restart from zero
		rows[11] = make_row(2, 2, 2, 1, 0, 0);
		for (int r = HAND_ROWS; r < NUM_ROWS; r++) begin
			a = idx_t'($urandom % 64);
			b = idx_t'($urandom % 64);
			c = idx_t'($urandom % 64);
			// Conflict when all three bank bits agree
			rows[r] = make_row(a, b, c, (a[0] == b[0]) && (b[0] == c[0]), 0, 0);
		end
	endtask

	task automatic run_row(int n);
		int waited;
		row_t r;
		r = rows[n];
		if (r.clear_first) begin
			stat_clear = 1'b1;
			@(posedge clock);
			#1 stat_clear = 1'b0;
		end
		issue = 1'b1;
		issue_req = '{r.src_1, r.src_2, r.src_3};
		expected_conflict = r.exp_conflict;
		@(posedge clock);
		#1 issue = 1'b0;
		if (r.late_write) begin
			write_enable = 1'b1;
			write_index = r.src_1;
			write_data = $urandom;
			@(posedge clock);
			#1 write_enable = 1'b0;
		end
		waited = 0;
		while (!operands_valid && waited < 5) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (!operands_valid) begin
			$display("Row %0d: operands_valid did not rise within 5 cycles of the issue", n);
			stim_errors++;
		end
	endtask

	initial begin
		reset = 1'b1;
		write_enable = 1'b0;
		write_index = '0;
		write_data = '0;
		issue = 1'b0;
		issue_req = '0;
		stat_clear = 1'b0;
		expected_conflict = 1'b0;
		stim_errors = 0;
		seed_value = $urandom(71783);
		repeat (4) @(posedge clock);
		#1 reset = 1'b0;
		for (int i = 0; i < `RF_REG_COUNT; i++) begin // Preload through the write port
			write_enable = 1'b1;
			write_index = idx_t'(i);
			write_data = $urandom;
			@(posedge clock);
			#1;
		end
		write_enable = 1'b0;
		build_table();
		for (int n = 0; n < NUM_ROWS; n++)
			run_row(n);
		repeat (3) @(posedge clock);
		if (fetches_seen != NUM_ROWS) begin
			$display("Checker saw %0d completed fetches, the table holds %0d", fetches_seen,
				NUM_ROWS);
			stim_errors++;
		end
		$display("Summary: %0d fetches, %0d check errors, %0d stimulus errors",
			fetches_seen, check_errors, stim_errors);
		if (check_errors + stim_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: test/operand_fetch_assert.sv
// Concurrent assertions on issue, busy, operands_valid and the reset values
`timescale 1ns/1ns

module operand_fetch_assert (
	input logic clock,
	input logic reset,
	input logic issue,
	input logic busy,
	input logic operands_valid,
	input logic bank_conflict,
	input rf_pkg::stat_t fetch_count,
	input rf_pkg::stat_t conflict_count
);

	no_issue_while_busy: assert property (@(posedge clock) disable iff (reset)
		!(issue && busy)) else $error("issue raised while busy was high");

	// Two cycles from issue to valid without a conflict and three with one
	plain_latency: assert property (@(posedge clock) disable iff (reset)
		(issue && !busy) ##1 !bank_conflict |=> !operands_valid ##1 (operands_valid && !busy))
		else $error("fetch without a bank conflict did not complete in 2 cycles");

	conflict_latency: assert property (@(posedge clock) disable iff (reset)
		(issue && !busy) ##1 bank_conflict |=> !operands_valid [*2] ##1
		(operands_valid && !busy))
		else $error("fetch with a bank conflict did not complete in 3 cycles");

	valid_one_cycle: assert property (@(posedge clock) disable iff (reset)
		operands_valid |=> !operands_valid) else $error("operands_valid held over two cycles");

	busy_drops_with_valid: assert property (@(posedge clock) disable iff (reset)
		$fell(busy) |-> operands_valid) else $error("busy fell outside a valid cycle");

	reset_values: assert property (@(posedge clock) $fell(reset) |->
		(!busy && !operands_valid && fetch_count == '0 && conflict_count == '0))
		else $error("outputs not cleared after reset");

endmodule

bind operand_fetch_top operand_fetch_assert u_operand_fetch_assert (
	.clock(clock), .reset(reset), .issue(issue), .busy(busy),
	.operands_valid(operands_valid), .bank_conflict(bank_conflict),
	.fetch_count(fetch_count), .conflict_count(conflict_count)
);

// File: test/operand_fetch_checker.sv
// Fetch checker: register model, expected operands, conflict flag and counter tallies
`timescale 1ns/1ns
`include "rf_defines.svh"

module operand_fetch_checker (
	input logic clock,
	input logic reset,
	input logic write_enable,
	input rf_pkg::idx_t write_index,
	input rf_pkg::data_t write_data,
	input logic issue,
	input rf_pkg::fetch_req_t issue_req,
	input logic expected_conflict,
	input logic stat_clear,
	input logic busy,
	input logic operands_valid,
	input logic bank_conflict,
	input rf_pkg::data_t operand_1,
	input rf_pkg::data_t operand_2,
	input rf_pkg::data_t operand_3,
	input rf_pkg::stat_t fetch_count,
	input rf_pkg::stat_t conflict_count,
	output int error_count,
	output int fetches_seen
);
	import rf_pkg::*;

	data_t model [`RF_REG_COUNT];
	data_t exp_op [1:3];
	fetch_req_t req;
	logic exp_conf, pending;
	int age, latency, errors_at_issue; // age counts edges since the issue edge
	stat_t fetch_tally, conflict_tally;

	initial begin
		error_count = 0;
		fetches_seen = 0;
	end

	task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
		$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
		error_count++;
	endtask

	function automatic stat_t bump(stat_t v);
		return (v == '1) ? v : stat_t'(v + 1'b1); // Held at the top
	endfunction

	////////////////////////////////////////
	// Model update at the clock edge
	////////////////////////////////////////

	always @(posedge clock) begin
		if (reset) begin
			pending = 1'b0;
			age = 0;
			fetch_tally = '0;
			conflict_tally = '0;
		end else begin
			if (pending) begin
				age++;
				if (age > latency)
					pending = 1'b0;
			end
			// Reads at this edge still see the old contents
			if (pending && age == 1) begin
				exp_op[1] = model[req.src_1];
				exp_op[2] = model[req.src_2];
				if (!exp_conf)
					exp_op[3] = model[req.src_3];
			end
			if (pending && age == 2 && exp_conf)
				exp_op[3] = model[req.src_3]; // Second pass
			if (stat_clear) begin
				fetch_tally = '0;
				conflict_tally = '0;
			end else if (pending && age == latency) begin
				fetch_tally = bump(fetch_tally);
				if (exp_conf)
					conflict_tally = bump(conflict_tally);
			end
			if (issue && !pending) begin
				pending = 1'b1;
				age = 0;
				req = issue_req;
				exp_conf = expected_conflict;
				latency = expected_conflict ? 3 : 2;
				errors_at_issue = error_count;
			end
			if (write_enable)
				model[write_index] = write_data;
		end
	end

	////////////////////////////////////////
	// Output compare between edges
	////////////////////////////////////////

	always @(negedge clock) begin
		if (!reset) begin
			if (pending && age == latency) begin // Valid cycle
				if (operands_valid !== 1'b1)
					report_mismatch("operands_valid", 1, operands_valid);
				if (busy !== 1'b0)
					report_mismatch("busy", 0, busy);
				if (operand_1 !== exp_op[1])
					report_mismatch("operand_1", exp_op[1], operand_1);
				if (operand_2 !== exp_op[2])
					report_mismatch("operand_2", exp_op[2], operand_2);
				if (operand_3 !== exp_op[3])
					report_mismatch("operand_3", exp_op[3], operand_3);
				if (bank_conflict !== exp_conf)
					report_mismatch("bank_conflict", exp_conf, bank_conflict);
				fetches_seen++;
				$display("Fetch %0d: sources %0d %0d %0d, conflict %0b, latency %0d, %s",
					fetches_seen, req.src_1, req.src_2, req.src_3, exp_conf, latency,
					(error_count == errors_at_issue) ? "ok" : "mismatch");
			end else if (pending) begin
				if (busy !== 1'b1)
					report_mismatch("busy", 1, busy);
				if (operands_valid !== 1'b0)
					report_mismatch("operands_valid", 0, operands_valid);
				if (bank_conflict !== exp_conf)
					report_mismatch("bank_conflict", exp_conf, bank_conflict);
			end else begin
				if (busy !== 1'b0)
					report_mismatch("busy", 0, busy);
				if (operands_valid !== 1'b0)
					report_mismatch("operands_valid", 0, operands_valid);
			end
			if (fetch_count !== fetch_tally)
				report_mismatch("fetch_count", fetch_tally, fetch_count);
			if (conflict_count !== conflict_tally)
				report_mismatch("conflict_count", conflict_tally, conflict_count);
		end
	end

endmodule

// File: logic/operand_fetch_top.sv
// Operand fetch lane top: FSM, port steering, two banks, collector and counters
`timescale 1ns/1ns

module operand_fetch_top (
	input logic clock,
	input logic reset,
	input logic write_enable,
	input rf_pkg::idx_t write_index,
	input rf_pkg::data_t write_data,
	input logic issue,
	input rf_pkg::fetch_req_t issue_req,
	input logic stat_clear,
	output logic busy,
	output logic operands_valid,
	output logic bank_conflict,
	output rf_pkg::data_t operand_1,
	output rf_pkg::data_t operand_2,
	output rf_pkg::data_t operand_3,
	output rf_pkg::stat_t fetch_count,
	output rf_pkg::stat_t conflict_count
);
	import rf_pkg::*;

	fetch_req_t cur_req;
	read_route_t route;
	logic second_pass, last_pass, conflict;
	logic fetch_done, conflict_seen;
	logic even_write, odd_write;
	bank_addr_t write_addr;
	data_t even_data_0, even_data_1, odd_data_0, odd_data_1;

	// Bank bit of the write index picks the bank
	assign write_addr = write_index[$bits(idx_t)-1:1];
	assign even_write = write_enable && !write_index[0];
	assign odd_write = write_enable && write_index[0];

	operand_fetch_fsm u_operand_fetch_fsm (
		.clock(clock), .reset(reset), .issue(issue), .issue_req(issue_req),
		.conflict(conflict), .cur_req(cur_req), .second_pass(second_pass),
		.last_pass(last_pass), .busy(busy), .conflict_flag(bank_conflict),
		.fetch_done(fetch_done), .conflict_seen(conflict_seen)
	);

	rf_index_sel u_rf_index_sel (
		.cur_req(cur_req), .second_pass(second_pass), .route(route), .conflict(conflict)
	);

	rf_bank u_even_bank (
		.clock(clock), .reset(reset), .write_enable(even_write), .write_addr(write_addr),
		.write_data(write_data), .read_addr_0(route.even_0.addr),
		.read_addr_1(route.even_1.addr), .read_data_0(even_data_0), .read_data_1(even_data_1)
	);

	rf_bank u_odd_bank (
		.clock(clock), .reset(reset), .write_enable(odd_write), .write_addr(write_addr),
		.write_data(write_data), .read_addr_0(route.odd_0.addr),
		.read_addr_1(route.odd_1.addr), .read_data_0(odd_data_0), .read_data_1(odd_data_1)
	);

	operand_collect u_operand_collect (
		.clock(clock), .reset(reset), .route(route), .last_pass(last_pass),
		.even_data_0(even_data_0), .even_data_1(even_data_1),
		.odd_data_0(odd_data_0), .odd_data_1(odd_data_1),
		.operand_1(operand_1), .operand_2(operand_2), .operand_3(operand_3),
		.operands_valid(operands_valid)
	);

	fetch_stat_counter u_fetch_stat_counter (
		.clock(clock), .reset(reset), .stat_clear(stat_clear), .fetch_done(fetch_done),
		.conflict_seen(conflict_seen), .fetch_count(fetch_count),
		.conflict_count(conflict_count)
	);

endmodule

// File: logic/fetch_stat_counter.sv
// Saturating fetch and conflict counters with synchronous clear
`timescale 1ns/1ns

module fetch_stat_counter (
	input logic clock,
	input logic reset,
	input logic stat_clear,
	input logic fetch_done,
	input logic conflict_seen,
	output rf_pkg::stat_t fetch_count,
	output rf_pkg::stat_t conflict_count
);
	import rf_pkg::*;

	// One step, held at the top value
	function automatic stat_t count_step(stat_t value, logic step);
		stat_t result;
		result = value;
		if (step && (value != '1))
			result = value + 1'b1;
		return result;
	endfunction

	////////////////////////////////////////
	// Counters
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset || stat_clear) begin // Clear wins over a count
			fetch_count <= '0;
			conflict_count <= '0;
		end else begin
			fetch_count <= count_step(fetch_count, fetch_done);
			conflict_count <= count_step(conflict_count, conflict_seen);
		end
	end

endmodule

// File: logic/operand_collect.sv
// Operand collector: delayed route, reorder of bank data into source order
`timescale 1ns/1ns

module operand_collect (
	input logic clock,
	input logic reset,
	input rf_pkg::read_route_t route,
	input logic last_pass,
	input rf_pkg::data_t even_data_0,
	input rf_pkg::data_t even_data_1,
	input rf_pkg::data_t odd_data_0,
	input rf_pkg::data_t odd_data_1,
	output rf_pkg::data_t operand_1,
	output rf_pkg::data_t operand_2,
	output rf_pkg::data_t operand_3,
	output logic operands_valid
);
	import rf_pkg::*;

	read_route_t route_q; // Lines up with the bank read latency
	port_route_t port_r [4];
	data_t port_data [4];
	data_t stage [1:3]; // Pass A results kept over pass B
	data_t fetched [1:3];

	assign port_r = '{route_q.even_0, route_q.even_1, route_q.odd_0, route_q.odd_1};
	assign port_data = '{even_data_0, even_data_1, odd_data_0, odd_data_1};

	// Each enabled port overrides the slot it serves
	always_comb begin
		fetched = stage;
		for (int p = 0; p < 4; p++) begin
			for (int n = 1; n <= 3; n++) begin
				if (port_r[p].enable && (port_r[p].src_sel == src_sel_t'(n)))
					fetched[n] = port_data[p];
			end
		end
	end

	always_ff @(posedge clock) begin
		stage <= fetched;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			route_q <= '0;
			operand_1 <= '0;
			operand_2 <= '0;
			operand_3 <= '0;
			operands_valid <= 1'b0;
		end else begin
			route_q <= route;
			operands_valid <= last_pass;
			if (last_pass) begin // Outputs change only when a fetch completes
				operand_1 <= fetched[1];
				operand_2 <= fetched[2];
				operand_3 <= fetched[3];
			end
		end
	end

endmodule

// File: logic/operand_fetch_fsm.sv
// Fetch sequencer: request capture, one or two read passes, drain and strobes
`timescale 1ns/1ns

module operand_fetch_fsm (
	input logic clock,
	input logic reset,
	input logic issue,
	input rf_pkg::fetch_req_t issue_req,
	input logic conflict,
	output rf_pkg::fetch_req_t cur_req,
	output logic second_pass,
	output logic last_pass,
	output logic busy,
	output logic conflict_flag,
	output logic fetch_done,
	output logic conflict_seen
);
	import rf_pkg::*;

	fetch_state_t state, next_state;
	logic accept; // Issue taken this cycle
	logic conflict_q; // Conflict of the fetch in flight

	assign accept = (state == IDLE) && issue;

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (issue)
					next_state = PASS_A;
			end
			PASS_A: begin
				if (conflict)
					next_state = PASS_B; // Source 3 still to read
				else
					next_state = DRAIN;
			end
			PASS_B: next_state = DRAIN;
			default: next_state = IDLE; // DRAIN
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			conflict_q <= 1'b0;
		end else begin
			state <= next_state;
			if (state == PASS_A)
				conflict_q <= conflict;
		end
	end

	// Request held for the steering during both passes
	always_ff @(posedge clock) begin
		if (accept)
			cur_req <= issue_req;
	end

	////////////////////////////////////////
	// Outputs
	////////////////////////////////////////

	assign busy = (state != IDLE);
	assign second_pass = (state == PASS_B);
	assign last_pass = (state == DRAIN); // Final read data at bank outputs
	assign fetch_done = (state == DRAIN);
	assign conflict_seen = (state == DRAIN) && conflict_q;

	// Live steering result in PASS_A, held afterwards
	assign conflict_flag = (state == PASS_A) ? conflict : conflict_q;

endmodule

// File: logic/rf_bank.sv
// Register bank with one write port and two registered read ports
`timescale 1ns/1ns
`include "rf_defines.svh"

module rf_bank (
	input logic clock,
	input logic reset,
	input logic write_enable,
	input rf_pkg::bank_addr_t write_addr,
	input rf_pkg::data_t write_data,
	input rf_pkg::bank_addr_t read_addr_0,
	input rf_pkg::bank_addr_t read_addr_1,
	output rf_pkg::data_t read_data_0,
	output rf_pkg::data_t read_data_1
);
	import rf_pkg::*;

	// Half of the register file
	data_t mem [`RF_REG_COUNT/2];

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (write_enable)
			mem[write_addr] <= write_data;
	end

	////////////////////////////////////////
	// Read ports, old value on a same-cycle write
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			read_data_0 <= '0;
			read_data_1 <= '0;
		end else begin
			read_data_0 <= mem[read_addr_0];
			read_data_1 <= mem[read_addr_1];
		end
	end

endmodule

// File: logic/rf_index_sel.sv
// Steering of three source indices onto the even and odd bank read ports
`timescale 1ns/1ns

module rf_index_sel (
	input rf_pkg::fetch_req_t cur_req,
	input logic second_pass,
	output rf_pkg::read_route_t route,
	output logic conflict
);
	import rf_pkg::*;

	logic [2:0] sel; // Bank bits of source 1, 2, 3

	// Enabled port reading one source
	function automatic port_route_t port_of(idx_t idx, src_sel_t src);
		port_route_t p;
		p.enable = 1'b1;
		p.addr = idx[$bits(idx_t)-1:1];
		p.src_sel = src;
		return p;
	endfunction

	assign sel = {cur_req.src_1[0], cur_req.src_2[0], cur_req.src_3[0]};

	// All three in one bank need two passes
	assign conflict = (sel == 3'h0) || (sel == 3'h7);

	always_comb begin
		route = '0; // Unused ports stay off at address zero
		if (second_pass) begin
			// Only source 3 is left after a conflict
			if (cur_req.src_3[0])
				route.odd_0 = port_of(cur_req.src_3, 2'd3);
			else
				route.even_0 = port_of(cur_req.src_3, 2'd3);
		end else begin
			case (sel)
				3'h0: begin // All even, source 3 deferred
					route.even_0 = port_of(cur_req.src_1, 2'd1);
					route.even_1 = port_of(cur_req.src_2, 2'd2);
				end
				3'h1: begin
					route.even_0 = port_of(cur_req.src_1, 2'd1);
					route.even_1 = port_of(cur_req.src_2, 2'd2);
					route.odd_0 = port_of(cur_req.src_3, 2'd3);
				end
				3'h2: begin
					route.even_0 = port_of(cur_req.src_1, 2'd1);
					route.even_1 = port_of(cur_req.src_3, 2'd3);
					route.odd_0 = port_of(cur_req.src_2, 2'd2);
				end
				3'h3: begin
					route.even_0 = port_of(cur_req.src_1, 2'd1);
					route.odd_0 = port_of(cur_req.src_2, 2'd2);
					route.odd_1 = port_of(cur_req.src_3, 2'd3);
				end
				3'h4: begin
					route.even_0 = port_of(cur_req.src_2, 2'd2);
					route.even_1 = port_of(cur_req.src_3, 2'd3);
					route.odd_0 = port_of(cur_req.src_1, 2'd1);
				end
				3'h5: begin
					route.even_0 = port_of(cur_req.src_2, 2'd2);
					route.odd_0 = port_of(cur_req.src_1, 2'd1);
					route.odd_1 = port_of(cur_req.src_3, 2'd3);
				end
				3'h6: begin
					route.even_0 = port_of(cur_req.src_3, 2'd3);
					route.odd_0 = port_of(cur_req.src_1, 2'd1);
					route.odd_1 = port_of(cur_req.src_2, 2'd2);
				end
				default: begin // All odd, source 3 deferred
					route.odd_0 = port_of(cur_req.src_1, 2'd1);
					route.odd_1 = port_of(cur_req.src_2, 2'd2);
				end
			endcase
		end
	end

endmodule

// File: logic/rf_pkg.sv
// Operand fetch types: vector widths, port route, fetch request and FSM state

`include "rf_defines.svh"

package rf_pkg;

	typedef logic [`RF_DATA_WIDTH-1:0] data_t;
	typedef logic [`RF_INDEX_WIDTH-1:0] idx_t;
	typedef logic [`RF_INDEX_WIDTH-2:0] bank_addr_t; // Index without bank bit
	typedef logic [1:0] src_sel_t; // Source slot 1..3, 0 unused
	typedef logic [`RF_STAT_WIDTH-1:0] stat_t;

	// One bank read port
	typedef struct packed {
		logic enable;
		bank_addr_t addr;
		src_sel_t src_sel;
	} port_route_t;

	// All four read ports of the lane
	typedef struct packed {
		port_route_t even_0;
		port_route_t even_1;
		port_route_t odd_0;
		port_route_t odd_1;
	} read_route_t;

	typedef struct packed {
		idx_t src_1;
		idx_t src_2;
		idx_t src_3;
	} fetch_req_t;

	typedef enum logic [1:0] {IDLE, PASS_A, PASS_B, DRAIN} fetch_state_t;

endpackage

// File: include/rf_defines.svh
// Register file widths, register count and statistics counter width

`ifndef RF_DEFINES_SVH
`define RF_DEFINES_SVH

////////////////////////////////////////
// Register file geometry
////////////////////////////////////////

// Width of one vector register element
`define RF_DATA_WIDTH 32

// Full source index, bit 0 picks the bank
`define RF_INDEX_WIDTH 6

`define RF_REG_COUNT 64 // Both banks together

////////////////////////////////////////
// Statistics
////////////////////////////////////////

`define RF_STAT_WIDTH 16 // Saturating event counters

`endif
